// ==== hdl/spi_defines.svh ====
// SPI master build constants

`ifndef SPI_DEFINES_SVH
`define SPI_DEFINES_SVH

////////////////////////////////////////////////////////////
// Frame geometry
////////////////////////////////////////////////////////////

// Number of bits shifted out and in during one frame.
`define SPI_WORD_LEN 8

////////////////////////////////////////////////////////////
// Clock divider
////////////////////////////////////////////////////////////

// Width of the divider select field in the configuration.
// Each half SCK period lasts 2**(div_sel + 1) clock cycles.
`define SPI_DIV_SEL_W 3

// Width of the divider counter, enough to reach 255.
`define SPI_DIV_CNT_W 8

`endif

// ==== hdl/spi_pkg.sv ====
// SPI master shared types

`default_nettype none

`include "spi_defines.svh"

package spi_pkg;

    ////////////////////////////////////////////////////////////
    // Vector types
    ////////////////////////////////////////////////////////////

    typedef logic [`SPI_WORD_LEN-1:0]  word_t;     // One data word.
    typedef logic [`SPI_DIV_SEL_W-1:0] div_sel_t;  // Divider select.
    typedef logic [`SPI_DIV_CNT_W-1:0] div_cnt_t;  // Divider count value.

    // Counts SCK toggles in a frame, which must reach 2 * SPI_WORD_LEN.
    typedef logic [$clog2(2 * `SPI_WORD_LEN + 1)-1:0] bit_cnt_t;

    ////////////////////////////////////////////////////////////
    // Per-word configuration
    ////////////////////////////////////////////////////////////

    // Captured with each word, so every frame may use its own mode.
    typedef struct packed {
        logic [1:0] mode;       // Bit 1 is CPOL and bit 0 is CPHA.
        logic       lsb_first;  // High sends and receives the LSB first.
        div_sel_t   div_sel;    // Half SCK period select.
    } spi_cfg_t;

    // Shift engine states.
    typedef enum logic {
        ST_IDLE,  // Waiting for a full transmit buffer.
        ST_BUSY   // A frame is in flight.
    } spi_state_e;

endpackage

`default_nettype wire

// ==== hdl/spi_tx_buffer.sv ====
// SPI transmit holding register

`timescale 1ns/1ps
`default_nettype none

`include "spi_defines.svh"

module spi_tx_buffer (
    input  logic              wr,
    input  logic              rst_n,
    input  logic              write,        // One-cycle host write strobe.
    input  spi_pkg::word_t    tx_data,
    input  spi_pkg::spi_cfg_t cfg,
    input  logic              clr_senderr,  // One-cycle error clear strobe.
    input  logic              take,         // Engine pulls the word out.
    output logic              full,
    output spi_pkg::word_t    buf_word,
    output spi_pkg::spi_cfg_t buf_cfg,
    output logic              tx_empty,
    output logic              senderr
);

    import spi_pkg::*;

    logic accept;  // A write that lands in an empty buffer.
    logic reject;  // A write that arrives while the word is still held.

    assign accept   = write && !full;
    assign reject   = write && full;
    assign tx_empty = ~full;  // The host sees the inverse of the full flag.

    // Full flag and sticky error.
    always_ff @(posedge wr or negedge rst_n) begin
        if (!rst_n) begin
            full    <= 1'b0;
            senderr <= 1'b0;
        end else begin
            // Take only comes while full, and accept only while empty.
            if (take) begin
                full <= 1'b0;
            end else if (accept) begin
                full <= 1'b1;
            end
            if (clr_senderr) begin
                senderr <= 1'b0;  // The clear beats a rejected write.
            end else if (reject) begin
                senderr <= 1'b1;
            end
        end
    end

    // The word and its configuration travel together.
    always_ff @(posedge wr) begin
        if (accept) begin
            buf_word <= tx_data;
            buf_cfg  <= cfg;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/spi_clk_divider.sv ====
// SPI half-period tick generator

`timescale 1ns/1ps
`default_nettype none

`include "spi_defines.svh"

module spi_clk_divider (
    input  logic              wr,
    input  logic              rst_n,
    input  logic              run,      // High while a frame is in flight.
    input  spi_pkg::div_sel_t div_sel,
    output logic              tick      // One pulse per half SCK period.
);

    import spi_pkg::*;

    div_cnt_t                 cnt;
    div_cnt_t                 mask;       // Terminal count for this select.
    logic [`SPI_DIV_SEL_W:0]  shift_amt;  // One wider so that 7 + 1 fits.

    // The mask holds div_sel + 1 ones, so the count wraps every
    // 2**(div_sel + 1) cycles.
    assign shift_amt = {1'b0, div_sel} + 1'b1;
    assign mask      = ~({`SPI_DIV_CNT_W{1'b1}} << shift_amt);

    assign tick = run && (cnt == mask);

    always_ff @(posedge wr or negedge rst_n) begin
        if (!rst_n) begin
            cnt <= '0;
        end else if (!run) begin
            cnt <= '0;  // Idle holds the count at zero.
        end else if (cnt == mask) begin
            cnt <= '0;  // Restart after each tick.
        end else begin
            cnt <= cnt + 1'b1;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/spi_shift_engine.sv ====
// SPI frame shift engine

`timescale 1ns/1ps
`default_nettype none

`include "spi_defines.svh"

module spi_shift_engine (
    input  logic              wr,
    input  logic              rst_n,
    input  logic              full,      // Transmit buffer holds a word.
    input  spi_pkg::word_t    buf_word,
    input  spi_pkg::spi_cfg_t buf_cfg,
    input  logic              tick,      // Half SCK period elapsed.
    input  logic              miso,
    output logic              take,      // Empties the transmit buffer.
    output logic              run,
    output spi_pkg::div_sel_t div_sel,
    output logic              done,      // Pulses as the frame ends.
    output spi_pkg::word_t    rx_word,
    output logic              sck,
    output logic              mosi,
    output logic              ss
);

    import spi_pkg::*;

    localparam int       WORD_LEN    = `SPI_WORD_LEN;
    localparam bit_cnt_t LAST_TOGGLE = bit_cnt_t'(2 * `SPI_WORD_LEN);

    spi_state_e state;
    bit_cnt_t   edge_cnt;    // SCK toggles so far in this frame.
    spi_cfg_t   cfg_q;       // Configuration latched at take.
    word_t      tx_sr;
    word_t      rx_sr;
    logic       mosi_q;
    logic       busy;
    logic       frame_end;   // The extra tick after the last toggle.
    logic       sample_now;
    logic       drive_now;

    ////////////////////////////////////////////////////////////
    // Edge decode
    ////////////////////////////////////////////////////////////

    assign busy = (state == ST_BUSY);
    assign take = (state == ST_IDLE) && full;

    assign frame_end = busy && tick && (edge_cnt == LAST_TOGGLE);

    // An even count means the next toggle is odd. CPHA 0 samples on odd
    // toggles and CPHA 1 on even ones, so the LSB of the count against
    // CPHA picks the sample edge.
    assign sample_now = busy && tick && !frame_end && (edge_cnt[0] == cfg_q.mode[0]);
    assign drive_now  = busy && tick && !frame_end && (edge_cnt[0] != cfg_q.mode[0]);

    assign run     = busy;
    assign div_sel = cfg_q.div_sel;  // The divider follows the frame's own select.
    assign done    = frame_end;
    assign rx_word = rx_sr;          // Complete once the last sample is in.

    // The count is even when idle, so SCK rests at CPOL.
    assign sck  = edge_cnt[0] ^ cfg_q.mode[1];
    assign mosi = ss ? 1'b1 : mosi_q;  // Released high outside a frame.

    ////////////////////////////////////////////////////////////
    // Frame control
    ////////////////////////////////////////////////////////////

    always_ff @(posedge wr or negedge rst_n) begin
        if (!rst_n) begin
            state    <= ST_IDLE;
            edge_cnt <= '0;
            cfg_q    <= '0;  // Mode 0, so SCK leaves reset low.
            ss       <= 1'b1;
            mosi_q   <= 1'b1;
        end else if (take) begin
            state    <= ST_BUSY;
            edge_cnt <= '0;
            cfg_q    <= buf_cfg;
            ss       <= 1'b0;
            // CPHA 0 needs the first bit valid before the first edge.
            if (!buf_cfg.mode[0]) begin
                mosi_q <= buf_cfg.lsb_first ? buf_word[0] : buf_word[WORD_LEN-1];
            end else begin
                mosi_q <= 1'b1;
            end
        end else if (frame_end) begin
            state    <= ST_IDLE;
            edge_cnt <= '0;
            if (!full) begin
                ss <= 1'b1;  // Nothing queued, so the frame closes.
            end
        end else if (busy && tick) begin
            edge_cnt <= edge_cnt + 1'b1;  // Each tick toggles SCK.
            if (drive_now) begin
                mosi_q <= cfg_q.lsb_first ? tx_sr[0] : tx_sr[WORD_LEN-1];
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Shift registers
    ////////////////////////////////////////////////////////////

    // The transmit register moves on the sample edge, so the drive edge
    // that follows finds the next bit at the output end.
    always_ff @(posedge wr) begin
        if (take) begin
            tx_sr <= buf_word;
        end else if (sample_now) begin
            if (cfg_q.lsb_first) begin
                tx_sr <= {1'b1, tx_sr[WORD_LEN-1:1]};  // Ones fill behind.
                rx_sr <= {miso, rx_sr[WORD_LEN-1:1]};
            end else begin
                tx_sr <= {tx_sr[WORD_LEN-2:0], 1'b1};
                rx_sr <= {rx_sr[WORD_LEN-2:0], miso};
            end
        end
    end

endmodule

`default_nettype wire

// ==== hdl/spi_rx_buffer.sv ====
// SPI receive register

`timescale 1ns/1ps
`default_nettype none

`include "spi_defines.svh"

module spi_rx_buffer (
    input  logic           wr,
    input  logic           rst_n,
    input  logic           done,          // End of frame from the engine.
    input  spi_pkg::word_t rx_word,
    input  logic           rd,            // One-cycle host read strobe.
    output spi_pkg::word_t rx_data,
    output logic           char_received
);

    import spi_pkg::*;

    word_t rx_q;  // Last completed word.

    assign rx_data = rx_q;  // Always visible; the read only drops the flag.

    // Received flag.
    always_ff @(posedge wr or negedge rst_n) begin
        if (!rst_n) begin
            char_received <= 1'b0;
        end else if (done) begin
            // A new word keeps the flag up even if a read lands now.
            char_received <= 1'b1;
        end else if (rd) begin
            char_received <= 1'b0;
        end
    end

    // An unread word is simply replaced by the next frame.
    always_ff @(posedge wr) begin
        if (done) begin
            rx_q <= rx_word;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/spi_master.sv ====
// SPI master top level

`timescale 1ns/1ps
`default_nettype none

`include "spi_defines.svh"

module spi_master (
    input  logic              wr,
    input  logic              rst_n,
    input  logic              write,
    input  spi_pkg::word_t    tx_data,
    input  spi_pkg::spi_cfg_t cfg,
    input  logic              clr_senderr,
    input  logic              rd,
    input  logic              miso,
    output spi_pkg::word_t    rx_data,
    output logic              tx_empty,
    output logic              senderr,
    output logic              char_received,
    output logic              sck,
    output logic              mosi,
    output logic              ss
);

    import spi_pkg::*;

    ////////////////////////////////////////////////////////////
    // Internal links
    ////////////////////////////////////////////////////////////

    logic     full;      // Buffer to engine.
    word_t    buf_word;
    spi_cfg_t buf_cfg;
    logic     take;      // Engine to buffer.
    logic     run;       // Engine to divider.
    div_sel_t div_sel;
    logic     tick;      // Divider to engine.
    logic     done;      // Engine to receive register.
    word_t    rx_word;

    spi_tx_buffer u_tx_buffer (
        .wr          (wr),
        .rst_n       (rst_n),
        .write       (write),
        .tx_data     (tx_data),
        .cfg         (cfg),
        .clr_senderr (clr_senderr),
        .take        (take),
        .full        (full),
        .buf_word    (buf_word),
        .buf_cfg     (buf_cfg),
        .tx_empty    (tx_empty),
        .senderr     (senderr)
    );

    spi_clk_divider u_clk_divider (
        .wr      (wr),
        .rst_n   (rst_n),
        .run     (run),
        .div_sel (div_sel),
        .tick    (tick)
    );

    spi_shift_engine u_shift_engine (
        .wr       (wr),
        .rst_n    (rst_n),
        .full     (full),
        .buf_word (buf_word),
        .buf_cfg  (buf_cfg),
        .tick     (tick),
        .miso     (miso),
        .take     (take),
        .run      (run),
        .div_sel  (div_sel),
        .done     (done),
        .rx_word  (rx_word),
        .sck      (sck),
        .mosi     (mosi),
        .ss       (ss)
    );

    spi_rx_buffer u_rx_buffer (
        .wr            (wr),
        .rst_n         (rst_n),
        .done          (done),
        .rx_word       (rx_word),
        .rd            (rd),
        .rx_data       (rx_data),
        .char_received (char_received)
    );

endmodule

`default_nettype wire

// ==== sim/spi_slave_model.sv ====
// Behavioral SPI slave

`timescale 1ns/1ps
`default_nettype none

module spi_slave_model #(
    parameter int WIDTH = 8
) (
    input  logic             wr,         // Sampled on this clock, like a synchronizer.
    input  logic             rst_n,
    input  logic             sck,
    input  logic             ss,
    input  logic             mosi,
    input  logic [1:0]       mode,       // Bit 1 is CPOL and bit 0 is CPHA.
    input  logic             lsb_first,
    input  logic [WIDTH-1:0] reply,      // Word returned on miso in each frame.
    output logic             miso,
    output logic [WIDTH-1:0] captured,   // Last complete word seen on mosi.
    output logic [15:0]      frame_cnt   // Counts words captured since reset.
);

    logic             ss_q;
    logic             sck_q;
    logic [WIDTH-1:0] shift_in;
    int               idx;    // Reply bit now on miso.
    int               nbits;  // Bits captured in the current word.

    // Picks reply bit number i in the chosen bit order.
    function automatic logic reply_bit(input int i);
        return lsb_first ? reply[i] : reply[WIDTH-1-i];
    endfunction

    ////////////////////////////////////////////////////////////
    // Edge detection and shifting
    ////////////////////////////////////////////////////////////

    // A rising edge samples when CPOL equals CPHA, a falling edge otherwise.
    always @(posedge wr or negedge rst_n) begin : slave_shift
        logic [WIDTH-1:0] next_word;
        int               next_idx;
        if (!rst_n) begin
            ss_q      <= 1'b1;
            sck_q     <= 1'b0;
            miso      <= 1'b1;
            idx       <= 0;
            nbits     <= 0;
            shift_in  <= '0;
            captured  <= '0;
            frame_cnt <= '0;
        end else if (ss) begin
            ss_q <= 1'b1;
        end else if (ss_q) begin
            // Frame start. SCK may just have moved to a new CPOL, which is no edge.
            ss_q  <= 1'b0;
            sck_q <= sck;
            idx   <= 0;
            nbits <= 0;
            miso  <= reply_bit(0);  // CPHA 0 needs bit 0 before the first edge.
        end else if (sck != sck_q) begin
            sck_q <= sck;
            if (sck == (mode[1] ~^ mode[0])) begin
                next_word = lsb_first ? {mosi, shift_in[WIDTH-1:1]}
                                      : {shift_in[WIDTH-2:0], mosi};
                shift_in <= next_word;
                if (nbits == WIDTH - 1) begin
                    captured  <= next_word;  // Published per word, so back-to-back works.
                    frame_cnt <= frame_cnt + 16'd1;
                    nbits     <= 0;
                end else begin
                    nbits <= nbits + 1;
                end
            end else begin
                next_idx = (idx == WIDTH - 1) ? 0 : idx + 1;
                idx <= next_idx;
                // CPHA 0 already shows the current bit, CPHA 1 shows it now.
                miso <= mode[0] ? reply_bit(idx) : reply_bit(next_idx);
            end
        end
    end

endmodule

`default_nettype wire

// ==== sim/tb_spi_master.sv ====
// SPI master testbench

`timescale 1ns/1ps
`default_nettype none

`include "spi_defines.svh"

module tb_spi_master;

    import spi_pkg::*;

    localparam int LIMIT = 20000;  // Cycle limit of every wait loop.

    logic        wr;
    logic        rst_n;
    logic        write;
    word_t       tx_data;
    spi_cfg_t    cfg;
    logic        clr_senderr;
    logic        rd;
    logic        miso;
    word_t       rx_data;
    logic        tx_empty;
    logic        senderr;
    logic        char_received;
    logic        sck;
    logic        mosi;
    logic        ss;
    logic [1:0]  s_mode;   // Slave side of the case setup.
    logic        s_lsb;
    word_t       s_reply;
    word_t       captured;
    logic [15:0] frame_cnt;
    int          fd;
    string       line;
    logic [31:0] c_mode, c_lsb, c_div, c_tx, c_reply, c_exp_mosi, c_exp_rx;
    logic [15:0] base;
    int          toggles;
    int          cyc;
    logic        prev_sck;
    int          dsel;     // Divider select under measurement.

    spi_master dut0 (
        .wr(wr), .rst_n(rst_n), .write(write), .tx_data(tx_data), .cfg(cfg),
        .clr_senderr(clr_senderr), .rd(rd), .miso(miso), .rx_data(rx_data),
        .tx_empty(tx_empty), .senderr(senderr), .char_received(char_received),
        .sck(sck), .mosi(mosi), .ss(ss)
    );

    spi_slave_model #(.WIDTH(`SPI_WORD_LEN)) slave0 (
        .wr(wr), .rst_n(rst_n), .sck(sck), .ss(ss), .mosi(mosi), .mode(s_mode),
        .lsb_first(s_lsb), .reply(s_reply), .miso(miso), .captured(captured),
        .frame_cnt(frame_cnt)
    );

    always #10 wr = ~wr;  // 20 ns period.

    ////////////////////////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////////////////////////

    task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            $display("ERROR: %s expected 0x%h got 0x%h", name, exp, act);
            $display("Test failed");
            $fatal(1);
        end
    endtask

    task automatic abort(input string msg);
        $display("%s", msg);
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic host_write(input word_t d, input spi_cfg_t c);
        @(posedge wr);
        write   <= 1'b1;
        tx_data <= d;
        cfg     <= c;
        @(posedge wr);
        write   <= 1'b0;
    endtask

    task automatic pulse_rd();
        @(posedge wr);
        rd <= 1'b1;
        @(posedge wr);
        rd <= 1'b0;
        @(posedge wr);  // Let the flag update settle before any check.
    endtask

    task automatic wait_ss(input logic level);
        int n;
        for (n = 0; n < LIMIT && ss !== level; n++) @(posedge wr);
        if (n == LIMIT) abort("Timeout while waiting for slave select to change.");
    endtask

    task automatic wait_received();
        int n;
        for (n = 0; n < LIMIT && char_received !== 1'b1; n++) @(posedge wr);
        if (n == LIMIT) abort("Timeout while waiting for a received word.");
    endtask

    // Slave select must stay low until the slave has seen the target count.
    task automatic wait_frames(input logic [15:0] target);
        int n;
        for (n = 0; n < LIMIT && frame_cnt != target; n++) begin
            check("ss", 32'd0, 32'(ss));
            @(posedge wr);
        end
        if (n == LIMIT) abort("Timeout while waiting for the slave to capture a word.");
    endtask

    ////////////////////////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////////////////////////

    initial begin
        wr          = 1'b0;
        rst_n       = 1'b0;
        write       = 1'b0;
        tx_data     = '0;
        cfg         = '0;
        clr_senderr = 1'b0;
        rd          = 1'b0;
        s_mode      = 2'd0;
        s_lsb       = 1'b0;
        s_reply     = '0;
        void'($urandom(82));
        repeat (5) @(posedge wr);
        rst_n <= 1'b1;
        @(posedge wr);
        @(posedge wr);

        // Idle levels out of reset.
        check("ss", 32'd1, 32'(ss));
        check("sck", 32'd0, 32'(sck));
        check("mosi", 32'd1, 32'(mosi));
        check("tx_empty", 32'd1, 32'(tx_empty));
        check("senderr", 32'd0, 32'(senderr));
        check("char_received", 32'd0, 32'(char_received));

        fd = $fopen("sim/spi_cases.txt", "r");
        if (fd == 0) abort("Could not open the case file sim/spi_cases.txt.");
        while ($fgets(line, fd) != 0) begin
            if (line.len() < 2 || line.substr(0, 0) == "#") continue;
            if ($sscanf(line, "%h %h %h %h %h %h %h", c_mode, c_lsb, c_div, c_tx,
                        c_reply, c_exp_mosi, c_exp_rx) != 7) continue;
            @(posedge wr);
            s_mode  <= c_mode[1:0];
            s_lsb   <= c_lsb[0];
            s_reply <= c_reply[7:0];
            base = frame_cnt;
            host_write(c_tx[7:0], '{mode: c_mode[1:0], lsb_first: c_lsb[0],
                                    div_sel: c_div[2:0]});
            wait_received();
            check("frame_cnt", 32'(base + 16'd1), 32'(frame_cnt));
            check("captured_mosi", c_exp_mosi, 32'(captured));
            check("rx_data", c_exp_rx, 32'(rx_data));
            wait_ss(1'b1);
            check("sck", 32'(c_mode[1]), 32'(sck));  // Rests at CPOL.
            pulse_rd();
            check("char_received", 32'd0, 32'(char_received));
            check("rx_data", c_exp_rx, 32'(rx_data));
            repeat ($urandom % 8) @(posedge wr);
        end
        $fclose(fd);

        // Back-to-back frames, a rejected third write and an unread overwrite.
        @(posedge wr);
        s_mode  <= 2'd1;
        s_lsb   <= 1'b0;
        s_reply <= 8'h6C;
        base = frame_cnt;
        host_write(8'hA1, '{mode: 2'd1, lsb_first: 1'b0, div_sel: 3'd1});
        wait_ss(1'b0);
        host_write(8'hB2, '{mode: 2'd1, lsb_first: 1'b0, div_sel: 3'd1});
        @(posedge wr);
        check("tx_empty", 32'd0, 32'(tx_empty));
        host_write(8'hC3, '{mode: 2'd1, lsb_first: 1'b0, div_sel: 3'd1});
        @(posedge wr);
        check("senderr", 32'd1, 32'(senderr));
        wait_frames(base + 16'd1);
        check("captured_mosi", 32'hA1, 32'(captured));
        s_reply <= 8'h95;  // CPHA 1 drives nothing until the next frame's first edge.
        wait_frames(base + 16'd2);
        wait_ss(1'b1);
        check("captured_mosi", 32'hB2, 32'(captured));
        check("char_received", 32'd1, 32'(char_received));
        check("rx_data", 32'h95, 32'(rx_data));
        check("tx_empty", 32'd1, 32'(tx_empty));
        repeat (40) begin
            @(posedge wr);
            check("ss", 32'd1, 32'(ss));
        end
        check("frame_cnt", 32'(base + 16'd2), 32'(frame_cnt));
        check("senderr", 32'd1, 32'(senderr));  // Still set long after the rejected write.
        @(posedge wr);
        clr_senderr <= 1'b1;
        @(posedge wr);
        clr_senderr <= 1'b0;
        @(posedge wr);
        check("senderr", 32'd0, 32'(senderr));
        pulse_rd();
        check("char_received", 32'd0, 32'(char_received));
        check("rx_data", 32'h95, 32'(rx_data));

        // SCK half period against the divider select.
        for (dsel = 0; dsel <= 2; dsel += 2) begin
            s_mode <= 2'd0;
            host_write(8'h3D, '{mode: 2'd0, lsb_first: 1'b0, div_sel: 3'(dsel)});
            wait_ss(1'b0);
            prev_sck = sck;
            toggles = 0;
            cyc = 0;
            while (ss === 1'b0 && cyc < LIMIT) begin
                @(posedge wr);
                cyc++;
                if (sck !== prev_sck) begin
                    if (toggles > 0) check("sck_half_period", 32'(2 ** (dsel + 1)), 32'(cyc));
                    toggles++;
                    cyc = 0;
                    prev_sck = sck;
                end
            end
            if (cyc >= LIMIT) abort("Timeout while measuring the SCK period.");
            check("sck_toggles", 32'(2 * `SPI_WORD_LEN), 32'(toggles));
            check("captured_mosi", 32'h3D, 32'(captured));
            pulse_rd();
        end

        $display("Test completed successfully");
        $finish;
    end

endmodule

`default_nettype wire

// ==== sim/spi_cases.txt ====
# mode lsb_first div_sel tx_word slave_reply expected_mosi expected_rx (all hex)
# mode bit 1 is CPOL and bit 0 is CPHA
0 0 0 A5 3C A5 3C
0 1 1 A5 3C A5 3C
1 0 0 5A C3 5A C3
1 1 2 81 7E 81 7E
2 0 1 F0 0F F0 0F
2 1 0 12 34 12 34
3 0 3 C6 9B C6 9B
3 1 0 E7 18 E7 18
0 0 2 01 80 01 80
1 1 1 80 01 80 01
2 0 0 FF 00 FF 00
3 1 1 00 FF 00 FF
0 1 0 6D D6 6D D6
1 0 3 39 93 39 93
2 1 2 B4 4B B4 4B
3 0 7 5C C5 5C C5

// ==== sim.f ====
+incdir+hdl
hdl/spi_pkg.sv
hdl/spi_tx_buffer.sv
hdl/spi_clk_divider.sv
hdl/spi_shift_engine.sv
hdl/spi_rx_buffer.sv
hdl/spi_master.sv
sim/spi_slave_model.sv
sim/tb_spi_master.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build with Verilator, run from the project root, then judge the log.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module tb_spi_master -f sim.f -Mdir obj_dir \
    -o sim_tb > build.log 2>&1 || { echo "Build failed, see build.log"; exit 1; }

./obj_dir/sim_tb > sim.log 2>&1

grep -q "Test failed" sim.log && { echo "FAIL, see sim.log"; exit 1; } \
    || { echo "PASS"; exit 0; }
